// ==== hdl/dma_write_settings.svh ====
`ifndef DMA_WRITE_SETTINGS_SVH
`define DMA_WRITE_SETTINGS_SVH

// Datapath widths
`define DMA_DATA_W 32
`define DMA_ADDR_W 32
`define DMA_LEN_W 16

// Words per burst, power of two
`define DMA_BURST_MAX 16

// Buffer depths as log2, data FIFO must hold a full burst
`define DMA_DATA_FIFO_AW 6
`define DMA_CMD_FIFO_AW 2

// Bursts waiting on B
`define DMA_MAX_OUTSTANDING 4

`endif

// ==== hdl/dma_write_pkg.sv ====
`include "dma_write_settings.svh"

package dma_write_pkg;

    typedef logic [`DMA_DATA_W-1:0] data_word_t;

    // Byte address, length in words
    typedef struct packed {
        logic [`DMA_ADDR_W-1:0] addr;
        logic [`DMA_LEN_W-1:0]  len;
    } dma_cmd_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [`DMA_ADDR_W-1:0] addr;
        logic [3:0]             len;
    } axi_aw_t;

    typedef struct packed {
        data_word_t               data;
        logic [`DMA_DATA_W/8-1:0] strb;
        logic                     last;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    localparam logic [7:0] REG_ADDR   = 8'h00;
    localparam logic [7:0] REG_LEN    = 8'h04;
    localparam logic [7:0] REG_STATUS = 8'h08;
    localparam logic [7:0] REG_DONE   = 8'h0C;

endpackage

// ==== hdl/dma_sync_fifo.sv ====
`timescale 1ns/100ps

module dma_sync_fifo #(
    parameter type T  = logic [31:0],
    parameter int  AW = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        push,
    input  T            wdata,
    input  logic        pop,
    output T            rdata,
    output logic        empty,
    output logic        full,
    output logic [AW:0] count
);

    localparam int DEPTH = 1 << AW;

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          wr_en;
    logic          rd_en;

    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == (AW+1)'(DEPTH));

    // First word falls through
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst) !(push && full)
    );

    a_no_underflow: assert property (
        @(posedge clk) disable iff (rst) !(pop && empty)
    );

endmodule

// ==== hdl/dma_apb_regs.sv ====
`timescale 1ns/100ps
`include "dma_write_settings.svh"

module dma_apb_regs import dma_write_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    output logic     cmd_push,
    output dma_cmd_t cmd,
    input  logic     cmd_full,
    input  logic     busy,
    input  logic     cmd_done,
    input  logic     b_error
);

    localparam int ADDR_W = `DMA_ADDR_W;
    localparam int LEN_W  = `DMA_LEN_W;

    logic [ADDR_W-1:0] addr_reg;
    logic              err_flag;
    logic [31:0]       done_cnt;
    logic              acc_wr;
    logic              len_wr;
    logic              stat_wr;
    logic [LEN_W-1:0]  new_len;
    logic              len_bad;
    logic [31:0]       rd_data;

    // Access phase, no wait states
    assign acc_wr  = apb_req.psel && apb_req.penable && apb_req.pwrite;
    assign len_wr  = acc_wr && (apb_req.paddr == REG_LEN);
    assign stat_wr = acc_wr && (apb_req.paddr == REG_STATUS);

    assign new_len = apb_req.pwdata[LEN_W-1:0];
    assign len_bad = (new_len == '0) || cmd_full;

    // Command goes straight into the queue on the REG_LEN write
    assign cmd_push = len_wr && !len_bad;
    assign cmd.addr = {addr_reg[ADDR_W-1:2], 2'b00};
    assign cmd.len  = new_len;

    always_comb begin
        rd_data = '0;
        case (apb_req.paddr)
            REG_ADDR:   rd_data = 32'(addr_reg);
            REG_STATUS: rd_data = {29'd0, err_flag, cmd_full, busy};
            REG_DONE:   rd_data = done_cnt;
            default:    rd_data = '0;
        endcase
    end

    assign apb_rsp.prdata  = rd_data;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = len_wr && len_bad;

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_reg <= '0;
            err_flag <= 1'b0;
            done_cnt <= '0;
        end else begin
            if (acc_wr && (apb_req.paddr == REG_ADDR)) begin
                addr_reg <= ADDR_W'(apb_req.pwdata);
            end
            // New error wins over a clear in the same cycle
            if (b_error) begin
                err_flag <= 1'b1;
            end else if (stat_wr) begin
                err_flag <= 1'b0;
            end
            if (cmd_done) begin
                done_cnt <= done_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/dma_burst_writer.sv ====
`timescale 1ns/100ps
`include "dma_write_settings.svh"

module dma_burst_writer import dma_write_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cmd_empty,
    input  dma_cmd_t                   cmd,
    output logic                       cmd_pop,
    input  logic [`DMA_DATA_FIFO_AW:0] fifo_count,
    input  logic                       fifo_empty,
    input  data_word_t                 fifo_rdata,
    output logic                       fifo_pop,
    output logic                       aw_valid,
    output axi_aw_t                    aw,
    input  logic                       aw_ready,
    output logic                       w_valid,
    output axi_w_t                     w,
    input  logic                       w_ready,
    input  logic                       b_valid,
    input  axi_b_t                     b,
    output logic                       b_ready,
    output logic                       cmd_done,
    output logic                       b_error,
    output logic                       busy
);

    localparam int ADDR_W = `DMA_ADDR_W;
    localparam int LEN_W  = `DMA_LEN_W;
    localparam int OFF_W  = $clog2(`DMA_BURST_MAX);
    localparam int BL_W   = OFF_W + 1;
    localparam int CNT_W  = `DMA_DATA_FIFO_AW + 1;
    localparam int QA     = $clog2(`DMA_MAX_OUTSTANDING);
    localparam int OUT_W  = QA + 1;

    logic              active;
    logic [ADDR_W-1:0] cur_addr;
    logic [LEN_W-1:0]  cur_rem;
    logic [ADDR_W-1:0] src_addr;
    logic [LEN_W-1:0]  src_rem;
    logic [BL_W-1:0]   room;
    logic [BL_W-1:0]   blen;
    logic              issue;
    logic              last_burst;
    logic              w_active;
    logic              aw_done;
    logic [BL_W-1:0]   w_left;
    logic [OUT_W-1:0]  out_cnt;
    logic [LEN_W-1:0]  cmd_bursts;
    logic [LEN_W-1:0]  b_seen;
    logic [LEN_W-1:0]  q_mem [`DMA_MAX_OUTSTANDING];
    logic [QA-1:0]     q_wr;
    logic [QA-1:0]     q_rd;
    logic [QA:0]       q_cnt;
    logic              q_push;
    logic              b_hs;
    logic              cmd_end;

    // Running command, or the queue head when idle
    assign src_addr = active ? cur_addr : cmd.addr;
    assign src_rem  = active ? cur_rem : cmd.len;

    // Stop at the next BURST_MAX-word boundary
    assign room = BL_W'(`DMA_BURST_MAX) - BL_W'(src_addr[2 +: OFF_W]);
    assign blen = (src_rem < LEN_W'(room)) ? BL_W'(src_rem) : room;
    assign last_burst = (src_rem == LEN_W'(blen));

    // Whole burst must already sit in the data FIFO
    assign issue = (active || !cmd_empty) && !w_active
                   && (fifo_count >= CNT_W'(blen))
                   && (out_cnt < OUT_W'(`DMA_MAX_OUTSTANDING));
    assign cmd_pop = issue && !active;

    assign fifo_pop = (aw_done || (aw_valid && aw_ready)) && (w_left != '0)
                      && (!w_valid || w_ready);

    assign b_ready = 1'b1;
    assign b_hs    = b_valid && b_ready;
    assign q_push  = issue && last_burst;
    assign cmd_end = b_hs && (q_cnt != '0) && ((b_seen + LEN_W'(1)) == q_mem[q_rd]);
    assign busy    = active || !cmd_empty || w_active || (out_cnt != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            active     <= 1'b0;
            aw_valid   <= 1'b0;
            aw_done    <= 1'b0;
            w_active   <= 1'b0;
            w_valid    <= 1'b0;
            w_left     <= '0;
            out_cnt    <= '0;
            cmd_bursts <= '0;
            b_seen     <= '0;
            q_wr       <= '0;
            q_rd       <= '0;
            q_cnt      <= '0;
            cmd_done   <= 1'b0;
            b_error    <= 1'b0;
        end else begin
            cmd_done <= cmd_end;
            b_error  <= b_hs && (b.resp != 2'b00);
            if (issue) begin
                active     <= !last_burst;
                aw_valid   <= 1'b1;
                aw_done    <= 1'b0;
                w_active   <= 1'b1;
                w_left     <= blen;
                cmd_bursts <= last_burst ? '0 : cmd_bursts + 1'b1;
            end else if (aw_valid && aw_ready) begin
                aw_valid <= 1'b0;
                aw_done  <= 1'b1;
            end
            if (fifo_pop) begin
                w_valid <= 1'b1;
                w_left  <= w_left - 1'b1;
            end else if (w_ready) begin
                w_valid <= 1'b0;
            end
            if (w_valid && w_ready && w.last) begin
                w_active <= 1'b0;
            end
            case ({issue, b_hs})
                2'b10:   out_cnt <= out_cnt + 1'b1;
                2'b01:   out_cnt <= out_cnt - 1'b1;
                default: out_cnt <= out_cnt;
            endcase
            if (b_hs) begin
                b_seen <= cmd_end ? '0 : b_seen + 1'b1;
            end
            // Burst totals per issued command, matched against B count
            if (q_push) begin
                q_wr <= q_wr + 1'b1;
            end
            if (cmd_end) begin
                q_rd <= q_rd + 1'b1;
            end
            case ({q_push, cmd_end})
                2'b10:   q_cnt <= q_cnt + 1'b1;
                2'b01:   q_cnt <= q_cnt - 1'b1;
                default: q_cnt <= q_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            cur_addr <= src_addr + (ADDR_W'(blen) << 2);
            cur_rem  <= src_rem - LEN_W'(blen);
            aw.addr  <= {src_addr[ADDR_W-1:2], 2'b00};
            aw.len   <= 4'(blen - 1'b1);
        end
        if (q_push) begin
            q_mem[q_wr] <= cmd_bursts + 1'b1;
        end
        if (fifo_pop) begin
            w.data <= fifo_rdata;
            w.strb <= '1;
            w.last <= (w_left == BL_W'(1));
        end
    end

    a_aw_hold: assert property (
        @(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw)
    );

    a_w_hold: assert property (
        @(posedge clk) disable iff (rst)
        w_valid && !w_ready |=> w_valid && $stable(w)
    );

    a_pop_data: assert property (
        @(posedge clk) disable iff (rst) !(fifo_pop && fifo_empty)
    );

endmodule

// ==== hdl/dma_write_top.sv ====
`timescale 1ns/100ps
`include "dma_write_settings.svh"

module dma_write_top import dma_write_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  apb_req_t   apb_req,
    output apb_rsp_t   apb_rsp,
    input  logic       in_valid,
    input  data_word_t in_data,
    output logic       in_ready,
    output logic       aw_valid,
    output axi_aw_t    aw,
    input  logic       aw_ready,
    output logic       w_valid,
    output axi_w_t     w,
    input  logic       w_ready,
    input  logic       b_valid,
    input  axi_b_t     b,
    output logic       b_ready
);

    logic                       cmd_push;
    dma_cmd_t                   cmd_in;
    dma_cmd_t                   cmd_head;
    logic                       cmd_pop;
    logic                       cmd_empty;
    logic                       cmd_full;
    logic                       data_push;
    logic                       data_pop;
    data_word_t                 data_head;
    logic                       data_empty;
    logic                       data_full;
    logic [`DMA_DATA_FIFO_AW:0] data_count;
    logic                       busy;
    logic                       cmd_done;
    logic                       b_error;

    assign in_ready  = !data_full;
    assign data_push = in_valid && in_ready;

    dma_apb_regs u_regs (
        .clk(clk), .rst(rst), .apb_req(apb_req), .apb_rsp(apb_rsp),
        .cmd_push(cmd_push), .cmd(cmd_in), .cmd_full(cmd_full),
        .busy(busy), .cmd_done(cmd_done), .b_error(b_error)
    );

    dma_sync_fifo #(.T(dma_cmd_t), .AW(`DMA_CMD_FIFO_AW)) u_cmd_fifo (
        .clk(clk), .rst(rst), .push(cmd_push), .wdata(cmd_in), .pop(cmd_pop),
        .rdata(cmd_head), .empty(cmd_empty), .full(cmd_full), .count()
    );

    dma_sync_fifo #(.T(data_word_t), .AW(`DMA_DATA_FIFO_AW)) u_data_fifo (
        .clk(clk), .rst(rst), .push(data_push), .wdata(in_data), .pop(data_pop),
        .rdata(data_head), .empty(data_empty), .full(data_full), .count(data_count)
    );

    dma_burst_writer u_writer (
        .clk(clk), .rst(rst),
        .cmd_empty(cmd_empty), .cmd(cmd_head), .cmd_pop(cmd_pop),
        .fifo_count(data_count), .fifo_empty(data_empty),
        .fifo_rdata(data_head), .fifo_pop(data_pop),
        .aw_valid(aw_valid), .aw(aw), .aw_ready(aw_ready),
        .w_valid(w_valid), .w(w), .w_ready(w_ready),
        .b_valid(b_valid), .b(b), .b_ready(b_ready),
        .cmd_done(cmd_done), .b_error(b_error), .busy(busy)
    );

endmodule

// ==== verif/axi_slave_model.sv ====
`timescale 1ns/100ps

module axi_slave_model import dma_write_pkg::*; #(
    parameter logic [31:0] ERR_LO = 32'h0,
    parameter logic [31:0] ERR_HI = 32'h0
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    stall,
    input  logic    aw_valid,
    input  axi_aw_t aw,
    output logic    aw_ready,
    input  logic    w_valid,
    input  axi_w_t  w,
    output logic    w_ready,
    output logic    b_valid,
    output axi_b_t  b,
    input  logic    b_ready
);

    localparam int WORDS = 1024;

    data_word_t  mem [WORDS];
    logic [31:0] aw_q [$];
    logic [1:0]  b_q [$];
    int          beat;
    logic        beat_err;

    // Untouched words read back as a function of their byte address
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = 32'hA5A5_0000 ^ 32'(i * 4);
        end
    end

    always @(posedge clk) begin
        logic [31:0] addr;
        if (rst) begin
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            b_valid  <= 1'b0;
            b        <= '0;
            aw_q.delete();
            b_q.delete();
            beat     = 0;
            beat_err = 1'b0;
        end else begin
            aw_ready <= !stall || ($urandom % 3 != 0);
            w_ready  <= !stall || ($urandom % 3 != 0);
            if (aw_valid && aw_ready) begin
                aw_q.push_back(aw.addr);
            end
            if (w_valid && w_ready) begin
                addr = aw_q[0] + 32'(beat * 4);
                // Beats in the window are dropped and answered with SLVERR
                if (addr >= ERR_LO && addr < ERR_HI) begin
                    beat_err = 1'b1;
                end else begin
                    mem[addr[11:2]] = w.data;
                end
                beat++;
                if (w.last) begin
                    b_q.push_back(beat_err ? 2'b10 : 2'b00);
                    void'(aw_q.pop_front());
                    beat     = 0;
                    beat_err = 1'b0;
                end
            end
            if (b_valid && b_ready) begin
                void'(b_q.pop_front());
            end
            b_valid <= (b_q.size() != 0);
            b.resp  <= (b_q.size() != 0) ? b_q[0] : 2'b00;
        end
    end

endmodule

// ==== verif/tb_dma_write.sv ====
`timescale 1ns/100ps
`include "dma_write_settings.svh"

module tb_dma_write import dma_write_pkg::*; ();

    localparam int          BURST       = `DMA_BURST_MAX;
    localparam int          MEM_WORDS   = 1024;
    localparam logic [31:0] ERR_LO      = 32'h3A0;
    localparam logic [31:0] ERR_HI      = 32'h3C0;
    localparam int          TOTAL_WORDS = 248;

    typedef axi_aw_t aw_list_t[$];

    logic        clk, rst, stall, stream_hold, stream_slow;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        in_valid, in_ready;
    data_word_t  in_data;
    logic        aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    axi_aw_t     aw;
    axi_w_t      w;
    axi_b_t      b;
    data_word_t  stream_q [$];
    data_word_t  exp_data [$];
    axi_aw_t     exp_aw [$];
    logic [3:0]  wlen_q [$];
    data_word_t  exp_mem [MEM_WORDS];
    int          w_beat, errors, tests_pass, tests_fail;
    logic [31:0] done_target;

    dma_write_top DUT (
        .clk(clk), .rst(rst), .apb_req(apb_req), .apb_rsp(apb_rsp),
        .in_valid(in_valid), .in_data(in_data), .in_ready(in_ready),
        .aw_valid(aw_valid), .aw(aw), .aw_ready(aw_ready),
        .w_valid(w_valid), .w(w), .w_ready(w_ready),
        .b_valid(b_valid), .b(b), .b_ready(b_ready)
    );

    axi_slave_model #(.ERR_LO(ERR_LO), .ERR_HI(ERR_HI)) u_slave (
        .clk(clk), .rst(rst), .stall(stall),
        .aw_valid(aw_valid), .aw(aw), .aw_ready(aw_ready),
        .w_valid(w_valid), .w(w), .w_ready(w_ready),
        .b_valid(b_valid), .b(b), .b_ready(b_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Forty cycles per streamed word plus APB and reset overhead
    initial begin
        repeat (TOTAL_WORDS * 40 + 2000) @(posedge clk);
        $display("Timeout: the DMA did not finish all commands in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    always @(posedge clk) begin
        if (rst) begin
            in_valid <= 1'b0;
        end else if (!in_valid || in_ready) begin
            if (stream_q.size() != 0 && !stream_hold && (!stream_slow || $urandom % 4 == 0)) begin
                in_valid <= 1'b1;
                in_data  <= stream_q.pop_front();
            end else begin
                in_valid <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && b_ready !== 1'b1) begin
            $display("FAILED b_ready exp 1 got %h", b_ready);
            errors++;
        end
        if (!rst && aw_valid && aw_ready) begin
            if (exp_aw.size() == 0) begin
                $display("Unexpected AW burst at address %h", aw.addr);
                errors++;
            end else begin
                check_aw("aw", aw, exp_aw.pop_front());
            end
            wlen_q.push_back(aw.len);
        end
        if (!rst && w_valid && w_ready) begin
            if (exp_data.size() == 0) begin
                $display("Unexpected W beat with data %h", w.data);
                errors++;
            end else begin
                check_word("w.data", w.data, exp_data.pop_front());
            end
            if (w.strb !== {(`DMA_DATA_W/8){1'b1}}) begin
                $display("FAILED w.strb exp %h got %h", {(`DMA_DATA_W/8){1'b1}}, w.strb);
                errors++;
            end
            if (w.last !== (w_beat == int'(wlen_q[0]))) begin
                $display("FAILED w.last exp %h got %h", w_beat == int'(wlen_q[0]), w.last);
                errors++;
            end
            if (w_beat == int'(wlen_q[0])) begin
                w_beat = 0;
                void'(wlen_q.pop_front());
            end else begin
                w_beat++;
            end
        end
    end

    task automatic check_aw(input string name, input axi_aw_t got, input axi_aw_t want);
        if (got !== want) begin
            $display("FAILED %s exp %h got %h", name, want, got);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input data_word_t got, input data_word_t want);
        if (got !== want) begin
            $display("FAILED %s exp %h got %h", name, want, got);
            errors++;
        end
    endtask

    task automatic check_apb(input string name, input apb_rsp_t got, input apb_rsp_t want);
        if (got !== want) begin
            $display("FAILED %s exp %h got %h", name, want, got);
            errors++;
        end
    endtask

    // Bursts stop at each BURST-word boundary
    function automatic aw_list_t burst_list(input logic [31:0] addr, input int len);
        aw_list_t    bl;
        axi_aw_t     one;
        logic [31:0] a;
        int          rem, off, n;
        a   = {addr[31:2], 2'b00};
        rem = len;
        while (rem > 0) begin
            off      = int'((a >> 2) % BURST);
            n        = (rem < BURST - off) ? rem : BURST - off;
            one.addr = a;
            one.len  = 4'(n - 1);
            bl.push_back(one);
            a   += 32'(n * 4);
            rem -= n;
        end
        return bl;
    endfunction

    function automatic void image_cmd(input logic [31:0] addr, input data_word_t words[$]);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        foreach (words[i]) begin
            if (a < ERR_LO || a >= ERR_HI) begin
                exp_mem[a[11:2]] = words[i];
            end
            a += 32'd4;
        end
    endfunction

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                              output apb_rsp_t rsp);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: data};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(posedge clk);
        rsp = apb_rsp;
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic program_cmd(input logic [31:0] addr, input int len, input logic want_err);
        apb_rsp_t rsp;
        aw_list_t bl;
        apb_access(1'b1, REG_ADDR, addr, rsp);
        if (!want_err) begin
            bl = burst_list(addr, len);
            foreach (bl[i]) exp_aw.push_back(bl[i]);
            done_target++;
        end
        apb_access(1'b1, REG_LEN, 32'(len), rsp);
        rsp.prdata = '0;
        check_apb("REG_LEN write", rsp,
                  apb_rsp_t'{prdata: 32'h0, pready: 1'b1, pslverr: want_err});
    endtask

    // Random words for one command, into the stream and the memory image
    task automatic stream_words(input logic [31:0] addr, input int len);
        data_word_t words [$];
        for (int i = 0; i < len; i++) words.push_back($urandom);
        image_cmd(addr, words);
        foreach (words[i]) begin
            stream_q.push_back(words[i]);
            exp_data.push_back(words[i]);
        end
    endtask

    task automatic queue_cmd(input logic [31:0] addr, input int len, input logic want_err);
        program_cmd(addr, len, want_err);
        if (!want_err) begin
            stream_words(addr, len);
        end
    endtask

    task automatic wait_done();
        apb_rsp_t rsp;
        rsp = '0;
        while (rsp.prdata < done_target) begin
            apb_access(1'b0, REG_DONE, 32'h0, rsp);
        end
    endtask

    task automatic read_status(input logic [31:0] want);
        apb_rsp_t rsp;
        apb_access(1'b0, REG_STATUS, 32'h0, rsp);
        check_apb("REG_STATUS", rsp, apb_rsp_t'{prdata: want, pready: 1'b1, pslverr: 1'b0});
    endtask

    task automatic finish_test(input string name, input int err0);
        apb_rsp_t rsp;
        apb_access(1'b0, REG_DONE, 32'h0, rsp);
        check_apb("REG_DONE", rsp,
                  apb_rsp_t'{prdata: done_target, pready: 1'b1, pslverr: 1'b0});
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_word($sformatf("mem[%0d]", i), u_slave.mem[i], exp_mem[i]);
        end
        if (exp_aw.size() != 0 || exp_data.size() != 0) begin
            $display("Expected bursts or data beats never appeared in %s", name);
            errors++;
        end
        if (errors == err0) begin
            tests_pass++;
            $display("Test %s: passed", name);
        end else begin
            tests_fail++;
            $display("Test %s: failed", name);
        end
    endtask

    initial begin
        int       err0;
        apb_rsp_t st_rsp;
        apb_req     <= '0;
        in_valid    <= 1'b0;
        in_data     <= '0;
        stall       <= 1'b0;
        stream_hold <= 1'b0;
        stream_slow <= 1'b0;
        rst         <= 1'b1;
        errors      = 0;
        tests_pass  = 0;
        tests_fail  = 0;
        w_beat      = 0;
        done_target = 0;
        void'($urandom(31335));
        foreach (exp_mem[i]) exp_mem[i] = 32'hA5A5_0000 ^ 32'(i * 4);
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        err0 = errors;
        queue_cmd(32'h000, 16, 1'b0);
        wait_done();
        finish_test("1 aligned 16-word burst", err0);

        err0 = errors;
        queue_cmd(32'h01C, 37, 1'b0);
        queue_cmd(32'h104, 19, 1'b0);
        wait_done();
        finish_test("2 unaligned odd lengths", err0);

        err0 = errors;
        stall       <= 1'b1;
        stream_slow <= 1'b1;
        queue_cmd(32'h200, 23, 1'b0);
        queue_cmd(32'h260, 8, 1'b0);
        queue_cmd(32'h284, 40, 1'b0);
        queue_cmd(32'h330, 3, 1'b0);
        wait_done();
        stall       <= 1'b0;
        stream_slow <= 1'b0;
        finish_test("3 queued commands with stalls", err0);

        // Stream held off so the command queue fills
        err0 = errors;
        stream_hold <= 1'b1;
        queue_cmd(32'h400, 0, 1'b1);
        for (int i = 0; i < 4; i++) queue_cmd(32'h400 + 32'(i * 16), 2, 1'b0);
        queue_cmd(32'h440, 2, 1'b1);
        read_status(32'h3);
        stream_hold <= 1'b0;
        wait_done();
        // Words ahead of their command fill the data FIFO
        stream_words(32'h480, 70);
        repeat (100) @(posedge clk);
        if (in_ready !== 1'b0) begin
            $display("FAILED in_ready exp 0 got %h", in_ready);
            errors++;
        end
        program_cmd(32'h480, 70, 1'b0);
        wait_done();
        repeat (50) @(posedge clk);
        finish_test("4 zero length and full queues", err0);

        err0 = errors;
        queue_cmd(32'h380, 24, 1'b0);
        wait_done();
        read_status(32'h4);
        queue_cmd(32'h0, 0, 1'b1);
        read_status(32'h4);
        apb_access(1'b1, REG_STATUS, 32'h0, st_rsp);
        read_status(32'h0);
        finish_test("5 error window", err0);

        $display("Tests passed: %0d  failed: %0d", tests_pass, tests_fail);
        if (errors == 0 && tests_fail == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/dma_write_pkg.sv
hdl/dma_sync_fifo.sv
hdl/dma_apb_regs.sv
hdl/dma_burst_writer.sv
hdl/dma_write_top.sv
verif/axi_slave_model.sv
verif/tb_dma_write.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_dma_write -o sim_dma \
    && ./obj_dir/sim_dma > sim.log 2>&1 \
    || { echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
echo "Simulation finished without failure"
exit 0
